//--- build.f
design/dmem_pkg.sv
design/mem_req_if.sv
design/host_port.sv
design/snapshot_loader.sv
design/data_mem.sv
design/read_response.sv
design/dmem_top.sv
verification/clk_gen.sv
verification/dmem_tb.sv

//--- design/data_mem.sv
module data_mem #(
  parameter int depth      = dmem_pkg::mem_depth_dflt,
  parameter int snap_words = dmem_pkg::snap_words_dflt
) (
  input  logic            clk_50,
  input  logic            rst,
  mem_req_if.dst          req,
  input  logic            copying,
  input  dmem_pkg::word_t snap_data [snap_words],
  output dmem_pkg::word_t rd_data,
  output logic            rd_done,
  output logic            wr_done,
  output logic            err_done
);

  dmem_pkg::word_t mem_cell [depth];

  logic do_write;
  logic do_read;

  // error requests never reach the array
  assign do_write = req.valid & req.write & ~req.err;
  assign do_read  = req.valid & ~req.write & ~req.err;

  // ****************************************
  // array write and bulk copy
  // ****************************************
  always_ff @(posedge clk_50) begin
    if (copying) begin
      for (int i = 0; i < snap_words; i++)
        mem_cell[i] <= snap_data[i];
    end
    // last assignment wins, so a write overrides only its own cell
    if (do_write)
      mem_cell[req.word_addr] <= req.wdata;
  end

  // ****************************************
  // registered read
  // ****************************************
  always_ff @(posedge clk_50 or posedge rst) begin
    if (rst)
      rd_data <= '0;
    else if (do_read)
      rd_data <= mem_cell[req.word_addr];  // holds between reads
  end

  // completion flags, one per request so responses stay in order
  always_ff @(posedge clk_50 or posedge rst) begin
    if (rst) begin
      rd_done  <= 1'b0;
      wr_done  <= 1'b0;
      err_done <= 1'b0;
    end else begin
      rd_done  <= req.valid;
      wr_done  <= req.valid & req.write;
      err_done <= req.valid & req.err;
    end
  end

endmodule

//--- design/dmem_pkg.sv
package dmem_pkg;

  // ****************************************
  // widths
  // ****************************************
  localparam int data_w = 32;  // data word
  localparam int addr_w = 32;  // byte address from the host

  // ****************************************
  // sizes
  // ****************************************
  localparam int mem_depth_dflt  = 1024;  // words in the data memory
  localparam int snap_words_dflt = 27;    // snapshot copied into cells 0 and up

  // ****************************************
  // shared types
  // ****************************************
  typedef logic [data_w-1:0] word_t;

  // word index, byte address bits 11:2 at the default depth
  typedef logic [$clog2(mem_depth_dflt)-1:0] word_addr_t;

endpackage

//--- design/dmem_top.sv
module dmem_top #(
  parameter int depth      = dmem_pkg::mem_depth_dflt,
  parameter int snap_words = dmem_pkg::snap_words_dflt
) (
  input  logic                        clk_50,
  input  logic                        rst,
  input  logic                        rd_stb,
  input  logic                        wr_stb,
  input  logic [dmem_pkg::addr_w-1:0] addr,
  input  dmem_pkg::word_t             wdata,
  input  logic                        snap_stb,
  input  dmem_pkg::word_t             snap_word,
  input  logic                        snap_commit,
  output logic                        resp_valid,
  output dmem_pkg::word_t             resp_data,
  output logic                        resp_err,
  output logic                        copy_done,
  output logic                        snap_err
);

  logic            copying;
  dmem_pkg::word_t snap_data [snap_words];
  dmem_pkg::word_t rd_data;
  logic            rd_done;
  logic            wr_done;
  logic            err_done;

  mem_req_if req_if ();

  // ****************************************
  // input side
  // ****************************************
  host_port #(
    .depth (depth)
  ) host_port_i (
    .clk_50 (clk_50),
    .rst    (rst),
    .rd_stb (rd_stb),
    .wr_stb (wr_stb),
    .addr   (addr),
    .wdata  (wdata),
    .req    (req_if.src)
  );

  snapshot_loader #(
    .snap_words (snap_words)
  ) snapshot_loader_i (
    .clk_50      (clk_50),
    .rst         (rst),
    .snap_stb    (snap_stb),
    .snap_word   (snap_word),
    .snap_commit (snap_commit),
    .copying     (copying),
    .snap_data   (snap_data),
    .copy_done   (copy_done),
    .snap_err    (snap_err)
  );

  // ****************************************
  // memory and response
  // ****************************************
  data_mem #(
    .depth      (depth),
    .snap_words (snap_words)
  ) data_mem_i (
    .clk_50    (clk_50),
    .rst       (rst),
    .req       (req_if.dst),
    .copying   (copying),
    .snap_data (snap_data),
    .rd_data   (rd_data),
    .rd_done   (rd_done),
    .wr_done   (wr_done),
    .err_done  (err_done)
  );

  read_response read_response_i (
    .clk_50     (clk_50),
    .rst        (rst),
    .rd_data    (rd_data),
    .rd_done    (rd_done),
    .wr_done    (wr_done),
    .err_done   (err_done),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_err   (resp_err)
  );

endmodule

//--- design/host_port.sv
module host_port #(
  parameter int unsigned depth = dmem_pkg::mem_depth_dflt
) (
  input  logic                        clk_50,
  input  logic                        rst,
  input  logic                        rd_stb,
  input  logic                        wr_stb,
  input  logic [dmem_pkg::addr_w-1:0] addr,
  input  dmem_pkg::word_t             wdata,
  mem_req_if.src                      req
);

  localparam int unsigned byte_lim = 4 * depth;  // first byte address past the array

  logic any_stb;
  logic both_stb;
  logic misaligned;
  logic out_of_range;
  logic bad_req;

  // ****************************************
  // request check
  // ****************************************
  assign any_stb      = rd_stb | wr_stb;
  assign both_stb     = rd_stb & wr_stb;
  assign misaligned   = (addr[1:0] != 2'b00);
  assign out_of_range = (addr >= byte_lim);
  assign bad_req      = both_stb | misaligned | out_of_range;

  // ****************************************
  // request register
  // ****************************************
  always_ff @(posedge clk_50 or posedge rst) begin
    if (rst) begin
      req.valid <= 1'b0;
      req.write <= 1'b0;
      req.err   <= 1'b0;
    end else begin
      req.valid <= any_stb;
      req.write <= wr_stb;             // a double strobe is flagged as err anyway
      req.err   <= any_stb & bad_req;
    end
  end

  // address and data only move with a strobe
  always_ff @(posedge clk_50) begin
    if (any_stb) begin
      req.word_addr <= addr[$bits(dmem_pkg::word_addr_t)+1:2];  // byte -> word index
      req.wdata     <= wdata;
    end
  end

endmodule

//--- design/mem_req_if.sv
// one word request, host port to memory
interface mem_req_if;

  logic                 valid;      // one-cycle strobe per accepted request
  logic                 write;      // 1 = write, 0 = read
  dmem_pkg::word_addr_t word_addr;
  dmem_pkg::word_t      wdata;
  logic                 err;        // bad request, memory must not be touched

  modport src (
    output valid,
    output write,
    output word_addr,
    output wdata,
    output err
  );

  modport dst (
    input valid,
    input write,
    input word_addr,
    input wdata,
    input err
  );

endinterface

//--- design/read_response.sv
module read_response (
  input  logic            clk_50,
  input  logic            rst,
  input  dmem_pkg::word_t rd_data,
  input  logic            rd_done,
  input  logic            wr_done,
  input  logic            err_done,
  output logic            resp_valid,
  output dmem_pkg::word_t resp_data,
  output logic            resp_err
);

  logic no_data;  // writes and errors report zero

  assign no_data = wr_done | err_done;

  // ****************************************
  // response register
  // ****************************************
  always_ff @(posedge clk_50 or posedge rst) begin
    if (rst) begin
      resp_valid <= 1'b0;
      resp_err   <= 1'b0;
      resp_data  <= '0;
    end else begin
      resp_valid <= rd_done;
      resp_err   <= rd_done & err_done;
      if (rd_done)
        resp_data <= no_data ? '0 : rd_data;
    end
  end

endmodule

//--- design/snapshot_loader.sv
module snapshot_loader #(
  parameter int snap_words = dmem_pkg::snap_words_dflt
) (
  input  logic            clk_50,
  input  logic            rst,
  input  logic            snap_stb,
  input  dmem_pkg::word_t snap_word,
  input  logic            snap_commit,
  output logic            copying,
  output dmem_pkg::word_t snap_data [snap_words],
  output logic            copy_done,
  output logic            snap_err
);

  localparam int cnt_w = $clog2(snap_words + 1);

  logic [cnt_w-1:0] count;     // words collected so far
  logic             overflow;  // a word arrived with the buffer already full
  logic             full;
  logic             commit_ok;

  assign full      = (count == cnt_w'(snap_words));
  assign commit_ok = full & ~overflow;

  // ****************************************
  // count, overflow and commit pulses
  // ****************************************
  always_ff @(posedge clk_50 or posedge rst) begin
    if (rst) begin
      count    <= '0;
      overflow <= 1'b0;
      copying  <= 1'b0;
      snap_err <= 1'b0;
    end else begin
      copying  <= 1'b0;
      snap_err <= 1'b0;
      if (snap_commit) begin
        copying  <= commit_ok;
        snap_err <= ~commit_ok;
        count    <= '0;       // buffer restarts either way
        overflow <= 1'b0;
      end else if (snap_stb) begin
        if (full)
          overflow <= 1'b1;   // extra word dropped
        else
          count <= count + 1'b1;
      end
    end
  end

  // ****************************************
  // word buffer
  // ****************************************
  // words land in arrival order, slot = current count
  always_ff @(posedge clk_50) begin
    if (snap_stb && !snap_commit && !full)
      snap_data[count] <= snap_word;
  end

  // the host sees the copy flagged in the same cycle the memory is told to copy
  assign copy_done = copying;

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the dmem testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module dmem_tb -f build.f -o dmem_sim \
  > build.log 2>&1 &&
./obj_dir/dmem_sim > sim.log 2>&1 &&
grep -q "Done: no errors" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- verification/clk_gen.sv
module clk_gen #(
  parameter int rst_cycles = 4
) (
  output logic clk_50,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  // 50 MHz, 20 ns period
  initial begin
    clk_50 = 1'b0;
    forever #10 clk_50 = ~clk_50;
  end

  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(negedge clk_50);
    rst = 1'b0;  // released away from the sampling edge
  end

endmodule

//--- verification/dmem_tb.sv
module dmem_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int depth      = dmem_pkg::mem_depth_dflt;
  localparam int snap_words = dmem_pkg::snap_words_dflt;
  localparam int wait_lim   = 64;  // cycles allowed for any single wait

  logic                        clk_50;
  logic                        rst;
  logic                        rd_stb;
  logic                        wr_stb;
  logic [dmem_pkg::addr_w-1:0] addr;
  dmem_pkg::word_t             wdata;
  logic                        snap_stb;
  dmem_pkg::word_t             snap_word;
  logic                        snap_commit;
  logic                        resp_valid;
  dmem_pkg::word_t             resp_data;
  logic                        resp_err;
  logic                        copy_done;
  logic                        snap_err;

  // ****************************************
  // reference model state
  // ****************************************
  dmem_pkg::word_t model [int];          // word index -> expected contents
  dmem_pkg::word_t snap_pend [snap_words];
  int              snap_cnt;
  logic            snap_ovf;
  logic [32:0]     exp_q [$];            // {err, data} per request, in order
  logic [32:0]     exp_head;             // response due at the next edge
  logic            exp_copy_ok;          // driven along with snap_commit
  logic            idle_chk;
  logic [31:0]     lcg_state;
  int              pick [16];

  clk_gen clk_gen_i (
    .clk_50 (clk_50),
    .rst    (rst)
  );

  dmem_top dmem_top_i (
    .clk_50      (clk_50),
    .rst         (rst),
    .rd_stb      (rd_stb),
    .wr_stb      (wr_stb),
    .addr        (addr),
    .wdata       (wdata),
    .snap_stb    (snap_stb),
    .snap_word   (snap_word),
    .snap_commit (snap_commit),
    .resp_valid  (resp_valid),
    .resp_data   (resp_data),
    .resp_err    (resp_err),
    .copy_done   (copy_done),
    .snap_err    (snap_err)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ****************************************
  // checks
  // ****************************************
  resp_timing: assert property (@(posedge clk_50) disable iff (rst)
    resp_valid == $past(rd_stb | wr_stb, 3))
    else abort_run($sformatf("** Error at %0t ns: resp_valid %0b, not 3 cycles after a strobe",
                             $time, $sampled(resp_valid)));

  resp_match: assert property (@(posedge clk_50) disable iff (rst)
    resp_valid |-> ({resp_err, resp_data} == exp_head))
    else abort_run($sformatf("** Error at %0t ns: response err %0b data %h, expected err %0b data %h",
                             $time, $sampled(resp_err), $sampled(resp_data),
                             exp_head[32], exp_head[31:0]));

  err_quiet: assert property (@(posedge clk_50) disable iff (rst)
    !resp_valid |-> !resp_err)
    else abort_run($sformatf("** Error at %0t ns: resp_err high without resp_valid", $time));

  data_hold: assert property (@(posedge clk_50) disable iff (rst)
    !resp_valid |-> $stable(resp_data))
    else abort_run($sformatf("** Error at %0t ns: resp_data moved between responses", $time));

  copy_result: assert property (@(posedge clk_50) disable iff (rst)
    $past(snap_commit) |-> (copy_done == $past(exp_copy_ok)) && (snap_err == !$past(exp_copy_ok)))
    else abort_run($sformatf("** Error at %0t ns: copy_done %0b snap_err %0b after a commit",
                             $time, $sampled(copy_done), $sampled(snap_err)));

  copy_quiet: assert property (@(posedge clk_50) disable iff (rst)
    !$past(snap_commit) |-> !copy_done && !snap_err)
    else abort_run($sformatf("** Error at %0t ns: copy_done or snap_err with no commit", $time));

  idle_outputs: assert property (@(posedge clk_50) disable iff (rst)
    idle_chk |-> !resp_valid && !resp_err && !copy_done && !snap_err && (resp_data == '0))
    else abort_run($sformatf("** Error at %0t ns: outputs not idle after reset", $time));

  // next expected response is staged half a cycle ahead of its check
  always @(negedge clk_50) begin
    if (resp_valid) begin
      if (exp_q.size() == 0)
        abort_run("a response came back with no request outstanding");
      else
        exp_head = exp_q.pop_front();
    end
  end

  // ****************************************
  // stimulus helpers
  // ****************************************
  task automatic next_cycle();
    @(negedge clk_50);
    rd_stb      = 1'b0;
    wr_stb      = 1'b0;
    snap_stb    = 1'b0;
    snap_commit = 1'b0;
    exp_copy_ok = 1'b0;
  endtask

  task automatic drive_req(input logic rd, input logic wr,
                           input logic [dmem_pkg::addr_w-1:0] byte_addr,
                           input dmem_pkg::word_t d);
    logic bad;
    int   wi;
    bad = (rd & wr) | (byte_addr[1:0] != 2'b00) | (byte_addr >= 32'(4 * depth));
    wi  = int'(byte_addr[31:2]);
    rd_stb = rd;
    wr_stb = wr;
    addr   = byte_addr;
    wdata  = d;
    if (bad)
      exp_q.push_back({1'b1, 32'h0});  // rejected, memory untouched
    else if (wr) begin
      model[wi] = d;
      exp_q.push_back({1'b0, 32'h0});
    end else if (model.exists(wi))
      exp_q.push_back({1'b0, model[wi]});
    else
      abort_run($sformatf("read of word %0d that the testbench never wrote", wi));
  endtask

  task automatic read_words(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      next_cycle();
      drive_req(1'b1, 1'b0, 32'(i * 4), '0);
    end
  endtask

  task automatic drive_snap_word(input dmem_pkg::word_t d);
    snap_stb  = 1'b1;
    snap_word = d;
    if (snap_cnt == snap_words)
      snap_ovf = 1'b1;  // the loader drops it
    else begin
      snap_pend[snap_cnt] = d;
      snap_cnt++;
    end
  endtask

  task automatic load_snapshot(input int count);
    for (int i = 0; i < count; i++) begin
      next_cycle();
      drive_snap_word(next_rand());
    end
  endtask

  task automatic drive_commit();
    snap_commit = 1'b1;
    exp_copy_ok = (snap_cnt == snap_words) && !snap_ovf;
    if (exp_copy_ok) begin
      for (int i = 0; i < snap_words; i++)
        model[i] = snap_pend[i];
    end
    snap_cnt = 0;
    snap_ovf = 1'b0;
  endtask

  task automatic wait_copy_result();
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!(copy_done || snap_err) && n < wait_lim);
    if (!(copy_done || snap_err))
      abort_run("no copy_done or snap_err came back after a commit");
  endtask

  task automatic drain_responses();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < wait_lim) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0)
      abort_run($sformatf("%0d responses never came back", exp_q.size()));
    next_cycle();  // the last response is checked on the edge in between
  endtask

  // ****************************************
  // test sequence
  // ****************************************
  initial begin
    int n;
    rd_stb = 1'b0;
    wr_stb = 1'b0;
    addr = '0;
    wdata = '0;
    snap_stb = 1'b0;
    snap_word = '0;
    snap_commit = 1'b0;
    exp_copy_ok = 1'b0;
    idle_chk = 1'b0;
    exp_head = '0;
    snap_cnt = 0;
    snap_ovf = 1'b0;
    lcg_state = 32'h75f2_9f96;

    n = 0;
    while (rst !== 1'b0 && n < wait_lim) begin
      @(negedge clk_50);
      n++;
    end
    if (rst !== 1'b0)
      abort_run("reset was never released");

    idle_chk = 1'b1;  // quiet outputs straight after reset
    repeat (8) next_cycle();
    idle_chk = 1'b0;

    // low words first, later tests compare against them
    for (int i = 0; i <= snap_words; i++) begin
      next_cycle();
      drive_req(1'b0, 1'b1, 32'(i * 4), next_rand());
    end
    for (int i = 0; i < 16; i++) begin
      pick[i] = int'(next_rand() >> 22);
      next_cycle();
      drive_req(1'b0, 1'b1, 32'(pick[i] * 4), next_rand());
    end
    for (int i = 0; i < 16; i++) begin
      next_cycle();
      drive_req(1'b1, 1'b0, 32'(pick[i] * 4), '0);
    end

    // bad requests all alias word 100
    next_cycle();
    drive_req(1'b0, 1'b1, 32'd400, next_rand());
    next_cycle();
    drive_req(1'b1, 1'b1, 32'd400, 32'hdead_beef);
    next_cycle();
    drive_req(1'b0, 1'b1, 32'd402, 32'h1234_5678);
    next_cycle();
    drive_req(1'b0, 1'b1, 32'd4496, 32'h0bad_f00d);
    read_words(100, 100);

    load_snapshot(snap_words);
    next_cycle();
    drive_commit();
    wait_copy_result();
    read_words(0, snap_words);

    load_snapshot(snap_words - 1);
    next_cycle();
    drive_commit();
    wait_copy_result();
    read_words(0, snap_words - 1);
    load_snapshot(snap_words + 1);
    next_cycle();
    drive_commit();
    wait_copy_result();
    read_words(0, snap_words - 1);

    // write lands on the same edge as the copy
    load_snapshot(snap_words);
    next_cycle();
    drive_commit();
    drive_req(1'b0, 1'b1, 32'd20, next_rand());
    wait_copy_result();
    read_words(0, snap_words);

    drain_responses();
    $display("Done: no errors");
    $finish;
  end

endmodule
